// File: dmm_ctrl.f
logic/dmm_ctrl_pkg.sv
logic/spi_reg_slave.sv
logic/register_bank.sv
logic/precharge_modulator.sv
logic/output_mode_mux.sv
logic/dmm_ctrl_top.sv
verification/dmm_ctrl_properties.sv
verification/dmm_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dmm control testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  --top-module dmm_ctrl_tb \
  -f dmm_ctrl.f \
  --Mdir "$OBJ" -o dmm_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/dmm_ctrl_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
  echo "testbench reported failure"
  exit 1
fi

echo "simulation run complete"
exit 0

// File: verification/dmm_ctrl_tb.sv
////////////////////
// dmm control testbench
// drives spi frames into the control fpga, checks
// readback and the conditioning pins per mode
////////////////////

`timescale 1ns/1ps

module dmm_ctrl_tb;
  import dmm_ctrl_pkg::*;

  localparam int CLK_HALF    = 20;             // 40 ns clk
  localparam int RST_CYCLES  = 10;
  localparam int DRIVE_DLY   = 2;              // inputs change 2 ns after posedge
  localparam int SPI_HALF    = 4;              // clk per sclk phase
  localparam int CS_GAP      = 10;             // clk with cs_n high after a frame
  localparam int HOLD_CYCLES = 12;             // compare window per setting
  localparam int WAIT_LIMIT  = 200;            // clk before a wait gives up
  localparam int PC_DUR      = 5;              // precharge sample duration under test
  localparam int WATCHDOG_NS = 2_000_000;

  logic       clk;
  logic       rst_n;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       miso;
  logic [3:0] azmux;
  logic [3:0] himux;
  logic [3:0] himux2;
  logic [3:0] adcmux;
  logic [7:0] monitor;
  logic       sig_pc_sw;
  logic       led0;
  logic       cmpr_latch;
  logic       meas_complete;
  logic       spi_interrupt;

  cond_vec_t  pins;                            // pins put back into vector order
  int         err_cnt;
  int         test_err_base;
  int         test_cnt;
  reg_word_t  rng_state;

  // register shadows feeding the reference model
  logic [2:0] sh_mode;
  reg_word_t  sh_led;
  reg_word_t  sh_direct;
  logic       cmp_en;                          // comparing process armed
  logic       prev_pc;                         // sig_pc_sw one clk back

  dmm_ctrl_top #(
    .CNT_W (24)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .sclk          (sclk),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .miso          (miso),
    .azmux         (azmux),
    .himux         (himux),
    .himux2        (himux2),
    .sig_pc_sw     (sig_pc_sw),
    .led0          (led0),
    .monitor       (monitor),
    .adcmux        (adcmux),
    .cmpr_latch    (cmpr_latch),
    .meas_complete (meas_complete),
    .spi_interrupt (spi_interrupt)
  );

  assign pins = {spi_interrupt, meas_complete, cmpr_latch, adcmux, monitor,
                 led0, sig_pc_sw, himux2, himux, azmux};

  always #CLK_HALF clk = ~clk;

  ////////////////////
  // reference model

  function automatic reg_word_t xorshift32(input reg_word_t x);
    reg_word_t y;
    begin
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
    end
  endfunction

  // expected conditioning vector, pc and ps stand for the switch phase and its start pulse
  function automatic cond_vec_t expected_cond(input logic [2:0] m, input reg_word_t led,
                                              input reg_word_t dir, input logic pc,
                                              input logic ps);
    cond_vec_t v;
    begin
      v = '0;
      case (m)
        MODE_ONES:
          v = '1;
        MODE_DIRECT:
          v = dir[NUM_BITS-1:0];               // low 29 bits, field for field
        MODE_PRECHARGE:
        begin
          v                   = dir[NUM_BITS-1:0];
          v[IDX_SIG_PC_SW]    = pc;
          v[IDX_LED0]         = pc;            // led mirrors the switch
          v[IDX_MONITOR]      = ps;            // mon0 marks each new phase
        end
        MODE_PATTERN:
          v = '0;                              // pattern is checked step by step
        default:
          v[IDX_LED0] = led[0];                // led mode and undefined codes
      endcase
      return v;
    end
  endfunction

  ////////////////////
  // compare tasks

  task automatic check_word(input reg_word_t got, input reg_word_t exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cond(input cond_vec_t got, input cond_vec_t exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s pins %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // pins against the model on every falling clk
  always @(negedge clk)
  begin
    if (cmp_en)
      check_cond(pins, expected_cond(sh_mode, sh_led, sh_direct, sig_pc_sw,
                                     sig_pc_sw != prev_pc), "mode output");
    prev_pc <= sig_pc_sw;
  end

  ////////////////////
  // drivers and waits

  task automatic wait_clks(input int n);
    begin
      for (int i = 0; i < n; i++)
        @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  // one 40 bit mode 0 frame, returns what came back on miso
  task automatic spi_frame(input logic [FRAME_BITS-1:0] tx,
                           output logic [FRAME_BITS-1:0] rx);
    begin
      rx   = '0;
      cs_n = 1'b0;
      wait_clks(SPI_HALF);
      for (int i = FRAME_BITS-1; i >= 0; i--)
      begin
        mosi = tx[i];
        wait_clks(SPI_HALF);
        rx[i] = miso;                          // host samples ahead of the rising edge
        sclk  = 1'b1;
        wait_clks(SPI_HALF);
        sclk  = 1'b0;
      end
      wait_clks(SPI_HALF);
      cs_n = 1'b1;
      mosi = 1'b0;
      #1;
      check_bit(miso, 1'b0, "miso with cs_n high");
      wait_clks(CS_GAP);                       // write has landed by now
    end
  endtask

  // write and keep the shadows in step, compare is paused meanwhile
  task automatic spi_write(input reg_addr_t addr, input reg_word_t data);
    logic [FRAME_BITS-1:0] rx;
    begin
      cmp_en = 1'b0;
      spi_frame({1'b1, addr, data}, rx);
      case (addr)
        ADDR_LED:    sh_led    = data;
        ADDR_MODE:   sh_mode   = data[2:0];
        ADDR_DIRECT: sh_direct = data;
        default:     ;
      endcase
    end
  endtask

  task automatic spi_read(input reg_addr_t addr, output reg_word_t data);
    logic [FRAME_BITS-1:0] rx;
    begin
      spi_frame({1'b0, addr, 32'h0}, rx);
      data = rx[REG_W-1:0];
    end
  endtask

  task automatic hold_compare(input int n);
    begin
      cmp_en = 1'b1;
      wait_clks(n);
      cmp_en = 1'b0;
    end
  endtask

  // clk until sig_pc_sw leaves its present level, 0 on timeout
  task automatic wait_pc_toggle(output int cycles);
    logic level;
    begin
      level  = sig_pc_sw;
      cycles = 0;
      do
      begin
        @(negedge clk);
        cycles++;
      end
      while (sig_pc_sw == level && cycles < WAIT_LIMIT);
      if (sig_pc_sw == level)
      begin
        err_cnt++;
        cycles = 0;
        $display("timeout at %0t ns: sig_pc_sw did not toggle within %0d clk",
                 $time, WAIT_LIMIT);
      end
    end
  endtask

  task automatic finish_test(input string name);
    begin
      test_cnt++;
      if (err_cnt == test_err_base)
        $display("test %0d %s: ok", test_cnt, name);
      else
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
      test_err_base = err_cnt;
    end
  endtask

  ////////////////////
  // tests

  initial
  begin
    reg_word_t val;
    reg_word_t rd;
    cond_vec_t last;
    int        run;
    reg_addr_t rw_addrs[3];

    clk           = 1'b0;
    rst_n         = 1'b0;
    sclk          = 1'b0;
    cs_n          = 1'b1;
    mosi          = 1'b0;
    cmp_en        = 1'b0;
    prev_pc       = 1'b0;
    err_cnt       = 0;
    test_err_base = 0;
    test_cnt      = 0;
    rng_state     = 32'd37;
    sh_mode       = MODE_LED;
    sh_led        = '0;
    sh_direct     = '0;
    rw_addrs      = '{ADDR_LED, ADDR_DIRECT, ADDR_SAMPLE_DURATION};

    wait_clks(RST_CYCLES);
    rst_n = 1'b1;
    wait_clks(2);

    // reset state, all quiet and the id reads back
    check_bit(miso, 1'b0, "miso after reset");
    cmp_en = 1'b1;
    spi_read(ADDR_ID, rd);
    check_word(rd, DMM_ID, "id register");
    cmp_en = 1'b0;
    finish_test("reset state");

    // mode goes first so the outputs stay zero until it changes
    rng_state = xorshift32(rng_state);
    val = {rng_state[31:3], 3'd5};
    spi_write(ADDR_MODE, val);
    spi_read(ADDR_MODE, rd);
    check_word(rd, {29'd0, val[2:0]}, "mode low bits");
    foreach (rw_addrs[i])
    begin
      rng_state = xorshift32(rng_state);
      spi_write(rw_addrs[i], rng_state);
      spi_read(rw_addrs[i], rd);
      check_word(rd, rng_state, "register readback");
    end
    rng_state = xorshift32(rng_state);
    spi_write(7'h15, rng_state);               // unmapped
    spi_read(7'h15, rd);
    check_word(rd, '0, "unmapped address");
    rng_state = xorshift32(rng_state);
    spi_write(ADDR_ID, rng_state);
    spi_read(ADDR_ID, rd);
    check_word(rd, DMM_ID, "id after write");
    finish_test("register access");

    // led mode with bit 0 low then high, all ones, undefined code 6
    spi_write(ADDR_MODE, reg_word_t'(MODE_LED));
    for (int k = 0; k < 2; k++)
    begin
      rng_state = xorshift32(rng_state);
      spi_write(ADDR_LED, {rng_state[31:1], 1'(k)});
      hold_compare(HOLD_CYCLES);
    end
    spi_write(ADDR_MODE, reg_word_t'(MODE_ONES));
    hold_compare(HOLD_CYCLES);
    spi_write(ADDR_MODE, 32'd6);
    hold_compare(HOLD_CYCLES);
    finish_test("fixed modes");

    spi_write(ADDR_MODE, reg_word_t'(MODE_DIRECT));
    for (int k = 0; k < 3; k++)
    begin
      rng_state = xorshift32(rng_state);
      spi_write(ADDR_DIRECT, rng_state);
      hold_compare(HOLD_CYCLES);
    end
    finish_test("direct mode");

    // counter must step by one each clk
    spi_write(ADDR_MODE, reg_word_t'(MODE_PATTERN));
    @(negedge clk);
    last = pins;
    for (int k = 0; k < 100; k++)
    begin
      @(negedge clk);
      check_cond(pins, last + 1'b1, "pattern step");
      last = pins;
    end
    wait_clks(1);
    finish_test("test pattern");

    rng_state = xorshift32(rng_state);
    spi_write(ADDR_DIRECT, rng_state);
    spi_write(ADDR_SAMPLE_DURATION, PC_DUR);
    spi_write(ADDR_MODE, reg_word_t'(MODE_PRECHARGE));
    wait_pc_toggle(run);                       // line up on a phase edge
    #DRIVE_DLY;                                // arm clear of the falling edge
    cmp_en = 1'b1;
    for (int k = 0; k < 6; k++)
    begin
      wait_pc_toggle(run);
      check_word(reg_word_t'(run), PC_DUR, "precharge run length");
    end
    #DRIVE_DLY;
    cmp_en = 1'b0;
    wait_clks(1);
    spi_write(ADDR_SAMPLE_DURATION, 32'd1);    // too short, switch parks low
    cmp_en = 1'b1;
    for (int k = 0; k < 4 * PC_DUR; k++)
    begin
      @(negedge clk);
      check_bit(sig_pc_sw, 1'b0, "sig_pc_sw with duration 1");
    end
    wait_clks(1);
    cmp_en = 1'b0;
    finish_test("precharge mode");

    $display("tests %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // hard stop in case a frame or a wait never returns
  initial
  begin
    #(WATCHDOG_NS);
    $display("simulation did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: verification/dmm_ctrl_properties.sv
////////////////////
// dmm control assertions
// miso idle on the spi slave, ones mode and
// reset quiet outputs on the output mux
////////////////////

`timescale 1ns/1ps

module dmm_ctrl_properties #(
  parameter bit SPI_SIDE = 1'b0                // 1 on the spi slave, 0 on the output mux
) (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    cs_s,         // synchronized cs_n
  input logic                    miso,
  input dmm_ctrl_pkg::mode_t     mode,
  input dmm_ctrl_pkg::cond_vec_t cond_out
);
  import dmm_ctrl_pkg::*;

  logic mode_seen;                             // mode has left MODE_LED since reset

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      mode_seen <= 1'b0;
    else if (mode != MODE_LED)
      mode_seen <= 1'b1;
  end

  generate
    if (SPI_SIDE)
    begin : g_spi
      miso_idle: assert property (@(posedge clk) disable iff (!rst_n) cs_s |-> !miso)
        else $error("miso high while cs_n is high");
    end
    else
    begin : g_mux
      ones_out: assert property (@(posedge clk) disable iff (!rst_n)
                                 (mode == MODE_ONES) |=> (&cond_out))
        else $error("cond_out not all ones after MODE_ONES");
      reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                                    !mode_seen |-> (cond_out == '0))
        else $error("cond_out active before the first mode change");
    end
  endgenerate

endmodule

bind spi_reg_slave dmm_ctrl_properties #(.SPI_SIDE(1'b1)) spi_props_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cs_s     (cs_s),
  .miso     (miso),
  .mode     (dmm_ctrl_pkg::MODE_LED),
  .cond_out ('0)
);

bind output_mode_mux dmm_ctrl_properties #(.SPI_SIDE(1'b0)) mux_props_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cs_s     (1'b1),
  .miso     (1'b0),
  .mode     (mode),
  .cond_out (cond_out)
);

// File: logic/dmm_ctrl_top.sv
////////////////////
// dmm control fpga top
// spi register access, precharge modulation and
// mode muxed conditioning outputs
////////////////////

`timescale 1ns/1ps

module dmm_ctrl_top #(
  parameter int CNT_W = 24                     // precharge counter width
) (
  input  logic       clk,
  input  logic       rst_n,
  // spi from the mcu
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  // conditioning outputs
  output logic [3:0] azmux,                    // u414 {en, a2, a1, a0}
  output logic [3:0] himux,                    // u413
  output logic [3:0] himux2,                   // u402
  output logic       sig_pc_sw,
  output logic       led0,
  output logic [7:0] monitor,
  output logic [3:0] adcmux,                   // u902 current switches
  output logic       cmpr_latch,
  output logic       meas_complete,
  output logic       spi_interrupt
);
  import dmm_ctrl_pkg::*;

  logic      wr_en;
  reg_addr_t wr_addr;
  reg_word_t wr_data;
  reg_addr_t rd_addr;
  reg_word_t rd_data;
  reg_word_t led_reg;
  mode_t     mode;
  reg_word_t direct;
  reg_word_t sample_duration;
  logic      pc_phase;
  logic      phase_start;
  cond_vec_t cond_out;

  ////////////////////
  // register access

  spi_reg_slave spi_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .rd_data (rd_data),
    .miso    (miso),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr)
  );

  register_bank regs_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .led_reg         (led_reg),
    .mode            (mode),
    .direct          (direct),
    .sample_duration (sample_duration)
  );

  ////////////////////
  // modulation and outputs

  precharge_modulator #(
    .CNT_W (CNT_W)
  ) pc_mod_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .sample_duration (sample_duration[CNT_W-1:0]),   // upper bits ignored
    .pc_phase        (pc_phase),
    .phase_start     (phase_start)
  );

  output_mode_mux out_mux_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .led_bit     (led_reg[0]),
    .direct      (direct[NUM_BITS-1:0]),
    .pc_phase    (pc_phase),
    .phase_start (phase_start),
    .cond_out    (cond_out)
  );

  // split the vector onto the pins
  assign azmux         = cond_out[IDX_AZMUX +: MUX_W];
  assign himux         = cond_out[IDX_HIMUX +: MUX_W];
  assign himux2        = cond_out[IDX_HIMUX2 +: MUX_W];
  assign sig_pc_sw     = cond_out[IDX_SIG_PC_SW];
  assign led0          = cond_out[IDX_LED0];
  assign monitor       = cond_out[IDX_MONITOR +: MONITOR_W];
  assign adcmux        = cond_out[IDX_ADCMUX +: MUX_W];
  assign cmpr_latch    = cond_out[IDX_CMPR_LATCH];
  assign meas_complete = cond_out[IDX_MEAS_COMPLETE];
  assign spi_interrupt = cond_out[IDX_SPI_INTERRUPT];

endmodule

// File: logic/output_mode_mux.sv
////////////////////
// output mode mux
// builds the conditioning vector of the selected
// mode and registers it onto the outputs
////////////////////

`timescale 1ns/1ps

module output_mode_mux (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dmm_ctrl_pkg::mode_t     mode,
  input  logic                    led_bit,
  input  dmm_ctrl_pkg::cond_vec_t direct,
  input  logic                    pc_phase,
  input  logic                    phase_start,
  output dmm_ctrl_pkg::cond_vec_t cond_out
);
  import dmm_ctrl_pkg::*;

  cond_vec_t pattern_cnt;                      // free running test pattern
  cond_vec_t mode_vec;                         // selected vector, pre register

  ////////////////////
  // test pattern

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pattern_cnt <= '0;
    else
      pattern_cnt <= pattern_cnt + 1'b1;       // wraps at 2^29
  end

  ////////////////////
  // mode select

  always_comb
  begin
    case (mode)
      MODE_ONES:
        mode_vec = '1;
      MODE_PATTERN:
        mode_vec = pattern_cnt;
      MODE_DIRECT:
        mode_vec = direct;
      MODE_PRECHARGE:
      begin
        // direct drives the muxes, fpga owns the switch
        mode_vec                = direct;
        mode_vec[IDX_SIG_PC_SW] = pc_phase;
        mode_vec[IDX_LED0]      = pc_phase;    // visible on the led
        mode_vec[IDX_MONITOR]   = phase_start; // scope trigger on mon0
      end
      default:
      begin
        // MODE_LED and undefined codes
        mode_vec           = '0;
        mode_vec[IDX_LED0] = led_bit;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cond_out <= '0;
    else
      cond_out <= mode_vec;
  end

endmodule

// File: logic/precharge_modulator.sv
////////////////////
// precharge modulator
// toggles the precharge phase every sample duration
////////////////////

`timescale 1ns/1ps

module precharge_modulator #(
  parameter int CNT_W = 24
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [CNT_W-1:0] sample_duration,    // clk cycles per phase
  output logic             pc_phase,
  output logic             phase_start
);

  logic [CNT_W-1:0] cnt;                       // clk count in current phase
  logic             dur_valid;
  logic             phase_end;

  assign dur_valid = (sample_duration >= CNT_W'(2));
  // >= so a shorter duration written mid phase ends it at once
  assign phase_end = (cnt >= sample_duration - 1'b1);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cnt         <= '0;
      pc_phase    <= 1'b0;
      phase_start <= 1'b0;
    end
    else if (!dur_valid)
    begin
      cnt         <= '0;                       // idle, switch parked low
      pc_phase    <= 1'b0;
      phase_start <= 1'b0;
    end
    else if (phase_end)
    begin
      cnt         <= '0;
      pc_phase    <= ~pc_phase;                // flip, new phase starts now
      phase_start <= 1'b1;
    end
    else
    begin
      cnt         <= cnt + 1'b1;
      phase_start <= 1'b0;
    end
  end

endmodule

// File: logic/register_bank.sv
////////////////////
// control register bank
// led, mode, direct and sample duration registers
// with decoded writes and combinational readback
////////////////////

`timescale 1ns/1ps

module register_bank (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  dmm_ctrl_pkg::reg_addr_t wr_addr,
  input  dmm_ctrl_pkg::reg_word_t wr_data,
  input  dmm_ctrl_pkg::reg_addr_t rd_addr,
  output dmm_ctrl_pkg::reg_word_t rd_data,
  output dmm_ctrl_pkg::reg_word_t led_reg,
  output dmm_ctrl_pkg::mode_t     mode,
  output dmm_ctrl_pkg::reg_word_t direct,
  output dmm_ctrl_pkg::reg_word_t sample_duration
);
  import dmm_ctrl_pkg::*;

  ////////////////////
  // write decode

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      led_reg         <= '0;
      mode            <= MODE_LED;
      direct          <= '0;
      sample_duration <= '0;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        ADDR_LED:
          led_reg <= wr_data;
        ADDR_MODE:
          mode <= mode_t'(wr_data[2:0]);       // keeps low 3 bits, codes 5..7 too
        ADDR_DIRECT:
          direct <= wr_data;
        ADDR_SAMPLE_DURATION:
          sample_duration <= wr_data;
        default:
        begin
          // id and unmapped addresses drop the write
        end
      endcase
    end
  end

  ////////////////////
  // readback

  // combinational, the slave loads it in the cycle rd_addr settles
  always_comb
  begin
    case (rd_addr)
      ADDR_ID:
        rd_data = DMM_ID;
      ADDR_LED:
        rd_data = led_reg;
      ADDR_MODE:
        rd_data = REG_W'(mode);                // zero extended
      ADDR_DIRECT:
        rd_data = direct;
      ADDR_SAMPLE_DURATION:
        rd_data = sample_duration;
      default:
        rd_data = '0;                          // unmapped
    endcase
  end

endmodule

// File: logic/spi_reg_slave.sv
////////////////////
// spi register slave
// mode 0 slave sampled on clk, frames 40 bit
// transactions into register writes and reads
////////////////////

`timescale 1ns/1ps

module spi_reg_slave (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sclk,
  input  logic                    cs_n,
  input  logic                    mosi,
  input  dmm_ctrl_pkg::reg_word_t rd_data,
  output logic                    miso,
  output logic                    wr_en,
  output dmm_ctrl_pkg::reg_addr_t wr_addr,
  output dmm_ctrl_pkg::reg_word_t wr_data,
  output dmm_ctrl_pkg::reg_addr_t rd_addr
);
  import dmm_ctrl_pkg::*;

  localparam int CNT_BITS = $clog2(FRAME_BITS + 1);

  logic [2:0]            sync_a;               // {sclk, cs_n, mosi} first stage
  logic [2:0]            sync_b;               // second stage
  logic                  sclk_s, cs_s, mosi_s;
  logic                  sclk_d, cs_d;         // edge stage
  logic                  sclk_rise, sclk_fall;
  logic                  cs_rise, cs_fall;
  logic [CNT_BITS-1:0]   bit_cnt;
  logic [FRAME_BITS-1:0] rx_sr;
  logic [REG_W-1:0]      tx_sr;
  logic                  rd_load;
  logic                  miso_q;

  ////////////////////
  // pin synchronizer

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sync_a <= 3'b010;                        // cs_n idles high
      sync_b <= 3'b010;
      sclk_d <= 1'b0;
      cs_d   <= 1'b1;
    end
    else
    begin
      sync_a <= {sclk, cs_n, mosi};
      sync_b <= sync_a;
      sclk_d <= sclk_s;
      cs_d   <= cs_s;
    end
  end

  assign {sclk_s, cs_s, mosi_s} = sync_b;

  // sclk edges only count inside a frame
  assign sclk_rise = sclk_s & ~sclk_d & ~cs_s;
  assign sclk_fall = ~sclk_s & sclk_d & ~cs_s;
  assign cs_fall   = ~cs_s & cs_d;             // frame start
  assign cs_rise   = cs_s & ~cs_d;             // frame end

  ////////////////////
  // framing

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      rd_load <= 1'b0;
    end
    else
    begin
      rd_load <= 1'b0;
      if (cs_fall)
        bit_cnt <= '0;
      else if (sclk_rise)
      begin
        if (bit_cnt != '1)                     // saturate on overlong frames
          bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == CNT_BITS'(7))
          rd_load <= 1'b1;                     // 8th edge, address is in
      end
    end
  end

  // incoming bits, msb first
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      rx_sr <= {rx_sr[FRAME_BITS-2:0], mosi_s};
  end

  assign rd_addr = rx_sr[ADDR_W-1:0];          // valid once 8 bits are in

  // readback shifter, next bit goes out on each falling sclk
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tx_sr  <= '0;
      miso_q <= 1'b0;
    end
    else if (cs_s)
    begin
      tx_sr  <= '0;
      miso_q <= 1'b0;
    end
    else if (rd_load && !rx_sr[ADDR_W])        // rw bit low means read
      tx_sr <= rd_data;
    else if (sclk_fall)
    begin
      miso_q <= tx_sr[REG_W-1];
      tx_sr  <= {tx_sr[REG_W-2:0], 1'b0};
    end
  end

  // raw pin gate keeps miso quiet as soon as cs_n lifts
  assign miso = miso_q & ~cs_n;

  ////////////////////
  // write strobe

  // only a complete 40 bit write frame commits
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wr_en <= 1'b0;
    else
      wr_en <= cs_rise && (bit_cnt == CNT_BITS'(FRAME_BITS)) && rx_sr[FRAME_BITS-1];
  end

  always_ff @(posedge clk)
  begin
    if (cs_rise)
    begin
      wr_addr <= rx_sr[REG_W +: ADDR_W];       // frame bits 38:32
      wr_data <= rx_sr[REG_W-1:0];
    end
  end

endmodule

// File: logic/dmm_ctrl_pkg.sv
////////////////////
// dmm control package
// register map, conditioning vector layout,
// output modes and spi frame constants
////////////////////

package dmm_ctrl_pkg;

  ////////////////////
  // conditioning vector

  localparam int NUM_BITS = 29;                // 4x4 mux + 8 monitor + 5 singles

  typedef logic [NUM_BITS-1:0] cond_vec_t;

  // lowest bit of each field, use with +:
  localparam int IDX_AZMUX         = 0;        // 0..3
  localparam int IDX_HIMUX         = 4;        // 4..7
  localparam int IDX_HIMUX2        = 8;        // 8..11
  localparam int IDX_SIG_PC_SW     = 12;
  localparam int IDX_LED0          = 13;
  localparam int IDX_MONITOR       = 14;       // 14..21
  localparam int IDX_ADCMUX        = 22;       // 22..25, adc current switches
  localparam int IDX_CMPR_LATCH    = 26;
  localparam int IDX_MEAS_COMPLETE = 27;
  localparam int IDX_SPI_INTERRUPT = 28;

  localparam int MUX_W     = 4;                // a0, a1, a2, en
  localparam int MONITOR_W = 8;

  ////////////////////
  // register bank

  localparam int REG_W  = 32;
  localparam int ADDR_W = 7;

  typedef logic [REG_W-1:0]  reg_word_t;
  typedef logic [ADDR_W-1:0] reg_addr_t;

  localparam reg_addr_t ADDR_ID              = 7'h00;   // read only
  localparam reg_addr_t ADDR_LED             = 7'h07;
  localparam reg_addr_t ADDR_MODE            = 7'h09;
  localparam reg_addr_t ADDR_DIRECT          = 7'h0A;
  localparam reg_addr_t ADDR_SAMPLE_DURATION = 7'h0C;

  localparam reg_word_t DMM_ID = 32'h444D_4D01;          // "DMM" + rev 1

  // output modes, stored as low 3 bits of the mode register
  typedef enum logic [2:0] {
    MODE_LED       = 3'd0,
    MODE_ONES      = 3'd1,
    MODE_PATTERN   = 3'd2,
    MODE_DIRECT    = 3'd3,
    MODE_PRECHARGE = 3'd4
  } mode_t;

  ////////////////////
  // spi framing

  // rw bit, 7 bit address, 32 bit data. msb first
  localparam int FRAME_BITS = 40;

endpackage
